/* hw/uart_params.svh */
// ********************
// UART parameters
// Widths, register bit positions and reset values
// ********************
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`define UART_ADDR_W        4
`define UART_DATA_W        8
`define UART_DL_W          16
`define UART_OVERSAMPLE    16
`define UART_LCR_RESET     8'h03

// Line status bits
`define UART_LS_DR         0
`define UART_LS_OE         1
`define UART_LS_FE         3
`define UART_LS_THRE       5
`define UART_LS_TEMT       6

// Interrupt enable bits
`define UART_IE_RDA        0
`define UART_IE_THRE       1
`define UART_IE_RLS        2

`define UART_LC_DL         7
`define UART_MC_LOOP       4

`endif

/* hw/uart_pkg.sv */
// ********************
// UART types
// Register index, interrupt identity and serial FSM states
// ********************
`default_nettype none
`include "uart_params.svh"

package uart_pkg;

	typedef enum logic [`UART_ADDR_W-1:0] {
		REG_RB_TR = 4'd0,
		REG_IE    = 4'd1,
		REG_II    = 4'd2,
		REG_LC    = 4'd3,
		REG_MC    = 4'd4,
		REG_LS    = 4'd5,
		REG_SR    = 4'd7,
		REG_EN    = 4'd8
	} uart_reg_e;

	// Read back in the low nibble of IIR
	typedef enum logic [3:0] {
		INT_NONE = 4'd1,
		INT_THRE = 4'd2,
		INT_RDA  = 4'd4,
		INT_RLS  = 4'd6
	} uart_int_id_e;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

`default_nettype wire

/* hw/uart_baud_gen.sv */
// ********************
// UART baud generator
// Divides the clock by the divisor latch into a 16x tick
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_baud_gen (
	input  logic                  rvx_port_07,
	input  logic                  rvx_port_02,
	input  logic [`UART_DL_W-1:0] divisor,
	output logic                  baud_tick
);

	logic [`UART_DL_W-1:0] cnt;

	// Tick on every reload, one per divisor cycles
	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			cnt       <= '0;
			baud_tick <= 1'b0;
		end
		else if (divisor == '0)
		begin
			cnt       <= '0;
			baud_tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt       <= divisor - 1'b1;
			baud_tick <= 1'b1;
		end
		else
		begin
			cnt       <= cnt - 1'b1;
			baud_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/uart_rx_path.sv */
// ********************
// UART receive path
// Samples the line at mid bit, keeps RBR and its status flags
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_path (
	input  logic                    rvx_port_07,
	input  logic                    rvx_port_02,
	input  logic                    baud_tick,
	input  logic                    serial_in,
	input  logic                    rbr_read,
	input  logic                    lsr_read,
	output logic [`UART_DATA_W-1:0] rbr_data,
	output logic                    data_ready,
	output logic                    overrun,
	output logic                    framing_err
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_W);

	uart_pkg::rx_state_e     state;
	logic                    sync_q1;
	logic                    rx_in;
	logic [TICK_W-1:0]       tick_cnt;
	logic [BIT_W-1:0]        bit_cnt;
	logic [`UART_DATA_W-1:0] shift_reg;
	logic                    half_bit;
	logic                    bit_end;
	logic                    frame_done;

	assign half_bit   = baud_tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE / 2 - 1));
	assign bit_end    = baud_tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign frame_done = (state == uart_pkg::RX_STOP) && bit_end;

	// Line idles high
	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			sync_q1 <= 1'b1;
			rx_in   <= 1'b1;
		end
		else
		begin
			sync_q1 <= serial_in;
			rx_in   <= sync_q1;
		end
	end

	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			state    <= uart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end
		else
		begin
			case (state)
			uart_pkg::RX_IDLE:
			begin
				tick_cnt <= '0;
				if (baud_tick && !rx_in)
					state <= uart_pkg::RX_START;
			end
			uart_pkg::RX_START:
			begin
				// Reject glitches shorter than half a bit
				if (half_bit)
				begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					state    <= rx_in ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
				end
				else if (baud_tick)
					tick_cnt <= tick_cnt + 1'b1;
			end
			uart_pkg::RX_DATA:
			begin
				if (bit_end)
				begin
					tick_cnt <= '0;
					bit_cnt  <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(`UART_DATA_W - 1))
						state <= uart_pkg::RX_STOP;
				end
				else if (baud_tick)
					tick_cnt <= tick_cnt + 1'b1;
			end
			default:
			begin
				if (bit_end)
					state <= uart_pkg::RX_IDLE;
				else if (baud_tick)
					tick_cnt <= tick_cnt + 1'b1;
			end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge rvx_port_07)
	begin
		if ((state == uart_pkg::RX_DATA) && bit_end)
			shift_reg <= {rx_in, shift_reg[`UART_DATA_W-1:1]};
		if (frame_done)
			rbr_data <= shift_reg;
	end

	// ********************
	// Sticky status, set wins over clear
	// ********************
	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			data_ready  <= 1'b0;
			overrun     <= 1'b0;
			framing_err <= 1'b0;
		end
		else
		begin
			if (frame_done)
				data_ready <= 1'b1;
			else if (rbr_read)
				data_ready <= 1'b0;
			if (frame_done && data_ready && !rbr_read)
				overrun <= 1'b1;
			else if (lsr_read)
				overrun <= 1'b0;
			if (frame_done && !rx_in)
				framing_err <= 1'b1;
			else if (lsr_read)
				framing_err <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/uart_tx_path.sv */
// ********************
// UART transmit path
// One holding byte shifted out as start, 8 data, stop
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx_path (
	input  logic                    rvx_port_07,
	input  logic                    rvx_port_02,
	input  logic                    baud_tick,
	input  logic                    thr_load,
	input  logic [`UART_DATA_W-1:0] thr_data,
	output logic                    serial_out,
	output logic                    thr_empty,
	output logic                    tx_empty
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_W);

	uart_pkg::tx_state_e     state;
	logic [TICK_W-1:0]       tick_cnt;
	logic [BIT_W-1:0]        bit_cnt;
	logic [`UART_DATA_W-1:0] thr_reg;
	logic [`UART_DATA_W-1:0] shifter;
	logic                    bit_end;
	logic                    take;

	assign bit_end = baud_tick && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign take    = (state == uart_pkg::TX_IDLE) && baud_tick && !thr_empty;

	always_ff @(posedge rvx_port_07)
	begin
		if (thr_load)
			thr_reg <= thr_data;
		if (take)
			shifter <= thr_reg;
		else if ((state == uart_pkg::TX_DATA) && bit_end)
			shifter <= shifter >> 1;
	end

	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			state      <= uart_pkg::TX_IDLE;
			tick_cnt   <= '0;
			bit_cnt    <= '0;
			serial_out <= 1'b1;
			thr_empty  <= 1'b1;
			tx_empty   <= 1'b1;
		end
		else
		begin
			if (thr_load)
				thr_empty <= 1'b0;
			else if (take)
				thr_empty <= 1'b1;

			if ((state == uart_pkg::TX_IDLE) || bit_end)
				tick_cnt <= '0;
			else if (baud_tick)
				tick_cnt <= tick_cnt + 1'b1;

			case (state)
			uart_pkg::TX_IDLE:
			begin
				if (take)
				begin
					state      <= uart_pkg::TX_START;
					serial_out <= 1'b0;
				end
			end
			uart_pkg::TX_START:
			begin
				if (bit_end)
				begin
					state      <= uart_pkg::TX_DATA;
					serial_out <= shifter[0];
					bit_cnt    <= '0;
				end
			end
			uart_pkg::TX_DATA:
			begin
				if (bit_end && (bit_cnt == BIT_W'(`UART_DATA_W - 1)))
				begin
					state      <= uart_pkg::TX_STOP;
					serial_out <= 1'b1;
				end
				else if (bit_end)
				begin
					serial_out <= shifter[1];
					bit_cnt    <= bit_cnt + 1'b1;
				end
			end
			default:
			begin
				// Frame over, idle only if nothing is waiting
				if (bit_end)
				begin
					state    <= uart_pkg::TX_IDLE;
					tx_empty <= thr_empty;
				end
			end
			endcase

			if (thr_load)
				tx_empty <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/uart_regs.sv */
// ********************
// UART register block
// Host decode, control registers and read data mux
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_regs (
	input  logic                    rvx_port_07,
	input  logic                    rvx_port_02,
	input  logic                    reg_write,
	input  logic                    reg_read,
	input  logic [`UART_ADDR_W-1:0] reg_addr,
	input  logic [`UART_DATA_W-1:0] reg_wdata,
	output logic [`UART_DATA_W-1:0] reg_rdata,
	input  logic [`UART_DATA_W-1:0] rbr_data,
	input  logic                    data_ready,
	input  logic                    overrun,
	input  logic                    framing_err,
	input  logic                    thr_empty,
	input  logic                    tx_empty,
	input  uart_pkg::uart_int_id_e  int_id,
	output logic [`UART_DL_W-1:0]   divisor,
	output logic [2:0]              ier,
	output logic                    thr_load,
	output logic [`UART_DATA_W-1:0] thr_data,
	output logic                    rbr_read,
	output logic                    lsr_read,
	output logic                    iir_read,
	output logic                    loopback,
	output logic                    enable
);

	uart_pkg::uart_reg_e     reg_idx;
	logic [`UART_DATA_W-1:0] lcr;
	logic [4:0]              mcr;
	logic [`UART_DATA_W-1:0] scr;
	logic [`UART_DATA_W-1:0] lsr;
	logic                    dlab;

	assign reg_idx  = uart_pkg::uart_reg_e'(reg_addr);
	assign dlab     = lcr[`UART_LC_DL];
	assign loopback = mcr[`UART_MC_LOOP];

	// Access strobes, DLAB steals index 0 and 1
	assign thr_load = reg_write && (reg_idx == uart_pkg::REG_RB_TR) && !dlab;
	assign thr_data = reg_wdata;
	assign rbr_read = reg_read && (reg_idx == uart_pkg::REG_RB_TR) && !dlab;
	assign lsr_read = reg_read && (reg_idx == uart_pkg::REG_LS);
	assign iir_read = reg_read && (reg_idx == uart_pkg::REG_II);

	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			lcr     <= `UART_LCR_RESET;
			divisor <= '0;
			ier     <= '0;
			mcr     <= '0;
			scr     <= '0;
			enable  <= 1'b0;
		end
		else if (reg_write)
		begin
			case (reg_idx)
			uart_pkg::REG_RB_TR: if (dlab) divisor[7:0] <= reg_wdata;
			uart_pkg::REG_IE:
			begin
				if (dlab)
					divisor[15:8] <= reg_wdata;
				else
					ier <= reg_wdata[2:0];
			end
			uart_pkg::REG_LC: lcr <= reg_wdata;
			uart_pkg::REG_MC: mcr <= reg_wdata[4:0];
			uart_pkg::REG_SR: scr <= reg_wdata;
			uart_pkg::REG_EN: enable <= reg_wdata[0];
			default: ;
			endcase
		end
	end

	always_comb
	begin
		lsr                 = '0;
		lsr[`UART_LS_DR]    = data_ready;
		lsr[`UART_LS_OE]    = overrun;
		lsr[`UART_LS_FE]    = framing_err;
		lsr[`UART_LS_THRE]  = thr_empty;
		lsr[`UART_LS_TEMT]  = tx_empty;
	end

	always_comb
	begin
		case (reg_idx)
		uart_pkg::REG_RB_TR: reg_rdata = dlab ? divisor[7:0] : rbr_data;
		uart_pkg::REG_IE:    reg_rdata = dlab ? divisor[15:8] : {5'b0, ier};
		uart_pkg::REG_II:    reg_rdata = {4'b0, int_id};
		uart_pkg::REG_LC:    reg_rdata = lcr;
		uart_pkg::REG_MC:    reg_rdata = {3'b0, mcr};
		uart_pkg::REG_LS:    reg_rdata = lsr;
		uart_pkg::REG_SR:    reg_rdata = scr;
		uart_pkg::REG_EN:    reg_rdata = {7'b0, enable};
		default:             reg_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/uart_int_ctrl.sv */
// ********************
// UART interrupt control
// Priority RLS, RDA, THRE into IIR and the irq line
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_int_ctrl (
	input  logic                   rvx_port_07,
	input  logic                   rvx_port_02,
	input  logic                   thr_load,
	input  logic                   iir_read,
	input  logic                   thr_empty,
	input  logic                   data_ready,
	input  logic                   overrun,
	input  logic                   framing_err,
	input  logic [2:0]             ier,
	output uart_pkg::uart_int_id_e int_id,
	output logic                   irq
);

	logic thr_empty_q;
	logic thre_pend;
	logic rls_int;
	logic rda_int;
	logic thre_int;

	assign rls_int  = ier[`UART_IE_RLS] && (overrun || framing_err);
	assign rda_int  = ier[`UART_IE_RDA] && data_ready;
	assign thre_int = ier[`UART_IE_THRE] && thre_pend;

	always_ff @(posedge rvx_port_07 or posedge rvx_port_02)
	begin
		if (rvx_port_02)
		begin
			thr_empty_q <= 1'b1;
			thre_pend   <= 1'b0;
			int_id      <= uart_pkg::INT_NONE;
			irq         <= 1'b0;
		end
		else
		begin
			thr_empty_q <= thr_empty;
			// THRE is acked by a new byte or by reading IIR while it shows THRE
			if (thr_load || (iir_read && (int_id == uart_pkg::INT_THRE)))
				thre_pend <= 1'b0;
			else if (thr_empty && !thr_empty_q)
				thre_pend <= 1'b1;

			if (rls_int)
				int_id <= uart_pkg::INT_RLS;
			else if (rda_int)
				int_id <= uart_pkg::INT_RDA;
			else if (thre_int)
				int_id <= uart_pkg::INT_THRE;
			else
				int_id <= uart_pkg::INT_NONE;
			irq <= rls_int || rda_int || thre_int;
		end
	end

endmodule

`default_nettype wire

/* hw/uart_top.sv */
// ********************
// UART top level
// Register block, baud tick, both paths, loopback and pin gating
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_top (
	input  logic                    rvx_port_07,
	input  logic                    rvx_port_02,
	input  logic [`UART_ADDR_W-1:0] reg_addr,
	input  logic [`UART_DATA_W-1:0] reg_wdata,
	output logic [`UART_DATA_W-1:0] reg_rdata,
	input  logic                    reg_write,
	input  logic                    reg_read,
	output logic                    txd,
	input  logic                    rxd,
	output logic                    irq
);

	logic [`UART_DL_W-1:0]   divisor;
	logic [`UART_DATA_W-1:0] thr_data;
	logic [`UART_DATA_W-1:0] rbr_data;
	logic [2:0]              ier;
	uart_pkg::uart_int_id_e  int_id;
	logic baud_tick, thr_load, thr_empty, tx_empty;
	logic rbr_read, lsr_read, iir_read;
	logic data_ready, overrun, framing_err;
	logic loopback, enable;
	logic tx_serial, rx_serial;

	// Loopback takes the transmitter, a disabled port sees an idle line
	assign rx_serial = loopback ? tx_serial : (enable ? rxd : 1'b1);
	assign txd       = (loopback || !enable) ? 1'b1 : tx_serial;

	uart_regs u_regs (.*);

	uart_baud_gen u_baud (.rvx_port_07, .rvx_port_02, .divisor, .baud_tick);

	uart_rx_path u_rx (.rvx_port_07, .rvx_port_02, .baud_tick, .serial_in(rx_serial),
		.rbr_read, .lsr_read, .rbr_data, .data_ready, .overrun, .framing_err);

	uart_tx_path u_tx (.rvx_port_07, .rvx_port_02, .baud_tick, .thr_load, .thr_data,
		.serial_out(tx_serial), .thr_empty, .tx_empty);

	uart_int_ctrl u_int (.rvx_port_07, .rvx_port_02, .thr_load, .iir_read, .thr_empty,
		.data_ready, .overrun, .framing_err, .ier, .int_id, .irq);

endmodule

`default_nettype wire

/* tb/uart_assert.sv */
// ********************
// UART assertions
// Pin idling, THRE timing and irq masking
// ********************
`default_nettype none
`timescale 1ns/1ps

module uart_assert (
	input logic       rvx_port_07,
	input logic       rvx_port_02,
	input logic [2:0] ier,
	input logic       irq,
	input logic       txd,
	input logic       enable,
	input logic       loopback,
	input logic       thr_load,
	input logic       thr_empty,
	input logic       tx_empty
);

	int fail_count = 0;

	// irq is registered, so it follows ier one cycle later
	irq_masked: assert property (@(posedge rvx_port_07) disable iff (rvx_port_02)
		(ier == 3'b0) |=> !irq)
	else
	begin
		fail_count++;
		$error("irq high while all interrupt enables are clear");
	end

	txd_idle: assert property (@(posedge rvx_port_07) disable iff (rvx_port_02)
		(!enable || loopback) |-> txd)
	else
	begin
		fail_count++;
		$error("txd low while the port is disabled or in loopback");
	end

	thre_fall: assert property (@(posedge rvx_port_07) disable iff (rvx_port_02)
		thr_load |=> !thr_empty)
	else
	begin
		fail_count++;
		$error("thr_empty still high one cycle after thr_load");
	end

	temt_rise: assert property (@(posedge rvx_port_07) disable iff (rvx_port_02)
		$rose(tx_empty) |-> thr_empty)
	else
	begin
		fail_count++;
		$error("tx_empty rose with a byte still in the holding register");
	end

endmodule

bind uart_top uart_assert u_assert (
	.rvx_port_07(rvx_port_07),
	.rvx_port_02(rvx_port_02),
	.ier(ier),
	.irq(irq),
	.txd(txd),
	.enable(enable),
	.loopback(loopback),
	.thr_load(thr_load),
	.thr_empty(thr_empty),
	.tx_empty(tx_empty)
);

`default_nettype wire

/* tb/uart_tb.sv */
// ********************
// UART testbench
// Register access, loopback, overrun, framing and interrupt checks
// ********************
`default_nettype none
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tb;

	localparam int DIVISOR    = 4;
	localparam int BIT_CYCLES = `UART_OVERSAMPLE * DIVISOR;
	// Ten frames at divisor 4 take about 6400 cycles, the rest is margin
	localparam int MAX_CYCLES = 40000;

	localparam logic [7:0] LS_DR   = 8'h01 << `UART_LS_DR;
	localparam logic [7:0] LS_OE   = 8'h01 << `UART_LS_OE;
	localparam logic [7:0] LS_FE   = 8'h01 << `UART_LS_FE;
	localparam logic [7:0] LS_THRE = 8'h01 << `UART_LS_THRE;
	localparam logic [7:0] LS_TEMT = 8'h01 << `UART_LS_TEMT;

	logic                    rvx_port_07;
	logic                    rvx_port_02;
	logic [`UART_ADDR_W-1:0] reg_addr;
	logic [`UART_DATA_W-1:0] reg_wdata;
	logic [`UART_DATA_W-1:0] reg_rdata;
	logic                    reg_write;
	logic                    reg_read;
	logic                    txd;
	logic                    rxd;
	logic                    irq;

	int          errors;
	int          cycles;
	logic [31:0] rng;

	uart_top uut (.*);

	always #20 rvx_port_07 = ~rvx_port_07;

	always @(posedge rvx_port_07)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, a wait on the DUT never finished", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_byte(output logic [7:0] b);
		rng = xorshift(rng);
		b = rng[7:0];
	endtask

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		rvx_port_02 = 1'b1;
		repeat (10) @(posedge rvx_port_07);
		#1 rvx_port_02 = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
		@(posedge rvx_port_07);
		#1;
		reg_addr  = addr;
		reg_wdata = data;
		reg_write = 1'b1;
		@(posedge rvx_port_07);
		#1 reg_write = 1'b0;
	endtask

	// Read data is combinational, sampled mid cycle
	task automatic read_reg(input logic [3:0] addr, output logic [7:0] data);
		@(posedge rvx_port_07);
		#1;
		reg_addr = addr;
		reg_read = 1'b1;
		@(negedge rvx_port_07);
		data = reg_rdata;
		@(posedge rvx_port_07);
		#1 reg_read = 1'b0;
	endtask

	task automatic wait_status(input logic [7:0] mask, output logic [7:0] value);
		do
			read_reg(uart_pkg::REG_LS, value);
		while ((value & mask) == 8'h00);
	endtask

	task automatic wait_irq(input logic level);
		while (irq !== level)
			@(negedge rvx_port_07);
	endtask

	// Start bit, 8 data bits LSB first, then the given stop level
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge rvx_port_07);
			#1 rxd = frame[i];
			repeat (BIT_CYCLES - 1) @(posedge rvx_port_07);
		end
		@(posedge rvx_port_07);
		#1 rxd = 1'b1;
		repeat (BIT_CYCLES) @(posedge rvx_port_07);
	endtask

	// Waits for the start bit on txd, then samples each bit at its middle
	task automatic capture_txd(output logic [7:0] data, output logic stop_level);
		while (txd !== 1'b0)
			@(negedge rvx_port_07);
		repeat (BIT_CYCLES / 2) @(negedge rvx_port_07);
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CYCLES) @(negedge rvx_port_07);
			data[i] = txd;
		end
		repeat (BIT_CYCLES) @(negedge rvx_port_07);
		stop_level = txd;
	endtask

	task automatic check_irq_low(input string name);
		@(posedge rvx_port_07);
		#1 check_value(name, 8'h00, {7'b0, irq});
	endtask

	initial
	begin
		logic [7:0] value;
		logic [7:0] b1;
		logic [7:0] b2;
		logic       stop_level;
		int         afails;
		errors      = 0;
		cycles      = 0;
		rng         = 32'he6d4;
		rvx_port_07 = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		reg_write   = 1'b0;
		reg_read    = 1'b0;
		rxd         = 1'b1;
		apply_reset();

		// ********************
		// Reset values
		read_reg(uart_pkg::REG_LC, value);
		check_value("reset_lcr", 8'h03, value);
		read_reg(uart_pkg::REG_LS, value);
		check_value("reset_lsr", 8'h60, value);
		read_reg(uart_pkg::REG_II, value);
		check_value("reset_iir", 8'h01, value);
		read_reg(uart_pkg::REG_EN, value);
		check_value("reset_en", 8'h00, value);

		// ********************
		// Divisor and scratch readback
		next_byte(b1);
		next_byte(b2);
		write_reg(uart_pkg::REG_LC, 8'h83);
		write_reg(uart_pkg::REG_RB_TR, b1);
		write_reg(uart_pkg::REG_IE, b2);
		read_reg(uart_pkg::REG_RB_TR, value);
		check_value("dll_readback", b1, value);
		read_reg(uart_pkg::REG_IE, value);
		check_value("dlm_readback", b2, value);
		// A large divisor would hold the baud counter for too long
		apply_reset();
		write_reg(uart_pkg::REG_LC, 8'h83);
		write_reg(uart_pkg::REG_RB_TR, 8'(DIVISOR));
		write_reg(uart_pkg::REG_IE, 8'h00);
		read_reg(uart_pkg::REG_RB_TR, value);
		check_value("dll_set", 8'(DIVISOR), value);
		write_reg(uart_pkg::REG_LC, 8'h03);
		next_byte(b1);
		write_reg(uart_pkg::REG_SR, b1);
		read_reg(uart_pkg::REG_SR, value);
		check_value("scratch_readback", b1, value);
		write_reg(uart_pkg::REG_EN, 8'h01);
		write_reg(uart_pkg::REG_IE, 8'h05);
		read_reg(uart_pkg::REG_IE, value);
		check_value("ier_view", 8'h05, value);
		write_reg(uart_pkg::REG_IE, 8'h00);
		read_reg(uart_pkg::REG_EN, value);
		check_value("en_view", 8'h01, value);

		// ********************
		// Loopback byte and overrun
		write_reg(uart_pkg::REG_MC, 8'h10);
		next_byte(b1);
		write_reg(uart_pkg::REG_RB_TR, b1);
		wait_status(LS_DR, value);
		read_reg(uart_pkg::REG_RB_TR, value);
		check_value("loop_data", b1, value);
		read_reg(uart_pkg::REG_LS, value);
		check_value("loop_dr_clear", 8'h00, value & LS_DR);
		wait_status(LS_TEMT, value);
		read_reg(uart_pkg::REG_LS, value);
		check_value("loop_lsr_idle", 8'h60, value);

		next_byte(b1);
		next_byte(b2);
		write_reg(uart_pkg::REG_RB_TR, b1);
		wait_status(LS_THRE, value);
		write_reg(uart_pkg::REG_RB_TR, b2);
		wait_status(LS_OE, value);
		check_value("overrun_dr", LS_DR, value & LS_DR);
		read_reg(uart_pkg::REG_LS, value);
		check_value("overrun_clear", 8'h00, value & LS_OE);
		read_reg(uart_pkg::REG_RB_TR, value);
		check_value("overrun_data", b2, value);
		wait_status(LS_TEMT, value);

		// ********************
		// Framing error and interrupts
		write_reg(uart_pkg::REG_MC, 8'h00);
		write_reg(uart_pkg::REG_IE, 8'h04);
		next_byte(b1);
		send_frame(b1, 1'b0);
		wait_irq(1'b1);
		read_reg(uart_pkg::REG_II, value);
		check_value("rls_iir", 8'h06, value);
		read_reg(uart_pkg::REG_LS, value);
		check_value("framing_err", LS_FE, value & LS_FE);
		read_reg(uart_pkg::REG_RB_TR, value);

		write_reg(uart_pkg::REG_IE, 8'h01);
		next_byte(b1);
		send_frame(b1, 1'b1);
		wait_irq(1'b1);
		read_reg(uart_pkg::REG_II, value);
		check_value("rda_iir", 8'h04, value);
		read_reg(uart_pkg::REG_RB_TR, value);
		check_value("rx_data", b1, value);
		check_irq_low("rda_irq_drop");

		write_reg(uart_pkg::REG_IE, 8'h02);
		next_byte(b1);
		write_reg(uart_pkg::REG_RB_TR, b1);
		capture_txd(value, stop_level);
		check_value("txd_data", b1, value);
		check_value("txd_stop", 8'h01, {7'b0, stop_level});
		wait_status(LS_TEMT, value);
		wait_irq(1'b1);
		read_reg(uart_pkg::REG_II, value);
		check_value("thre_iir", 8'h02, value);
		check_irq_low("thre_irq_drop");

		// ********************
		// Disabled port keeps txd idle
		write_reg(uart_pkg::REG_IE, 8'h00);
		write_reg(uart_pkg::REG_EN, 8'h00);
		next_byte(b1);
		write_reg(uart_pkg::REG_RB_TR, b1);
		wait_status(LS_TEMT, value);

		afails = uut.u_assert.fail_count;
		$display("Value errors: %0d, assertion failures: %0d", errors, afails);
		if ((errors == 0) && (afails == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx_path.sv
hw/uart_tx_path.sv
hw/uart_regs.sv
hw/uart_int_ctrl.sv
hw/uart_top.sv
tb/uart_assert.sv
tb/uart_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_tb
RTL_TOP   ?= uart_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
